/* dump_macros.svh */
`ifndef DUMP_MACROS_SVH
`define DUMP_MACROS_SVH

// data region that gets dumped, both ends included.
`define DATA_START_ADDR 32'h0000_0000
`define DATA_END_ADDR   32'h0000_001C

// pc of the last instruction of the test program.
`define LAST_PC         32'h0000_0680

// cycles to wait after the last pc before test mode.
`define DRAIN_CYCLES    20

`define MEM_WORDS       16

// sck high and low time in clk_1khz cycles.
`define SCK_PULSE_WIDTH 2

`endif

/* mem_pkg.sv */
package mem_pkg;

    // access width of a core request.
    typedef enum logic [1:0] {
        dt_byte = 2'd0,
        dt_half = 2'd1,
        dt_word = 2'd2
    } mem_dt_e;

    typedef enum logic {
        err_none       = 1'b0,
        err_misaligned = 1'b1
    } errno_e;

    // one memory word, seen whole or as byte lanes.
    // b[0] is the lowest addressed byte.
    typedef union packed {
        logic [31:0]     w;
        logic [3:0][7:0] b;
    } mem_word_u;

    // data-memory request from the core.
    typedef struct packed {
        logic [31:0] addr;
        mem_word_u   wd;
        logic        we;
        mem_dt_e     dt;
    } mem_req_t;

endpackage

/* spi_pkg.sv */
package spi_pkg;

    // word handed to the SPI master, en is a level.
    typedef struct packed {
        logic        en;
        logic [31:0] word;
    } send_req_t;

    // pins of the write-only link.
    typedef struct packed {
        logic mosi;
        logic ss;
        logic sck;
    } spi_pins_t;

endpackage

/* data_mem.sv */
`include "dump_macros.svh"

module data_mem
    import mem_pkg::*;
(
    input  logic        clk_1khz,
    input  logic        rst,
    input  mem_req_t    core_req,
    input  logic        tm,
    input  logic [31:0] tm_addr,
    output logic [31:0] core_rd,
    output errno_e      core_err,
    output logic [31:0] tm_rd
);
    localparam int IDX_W = $clog2(`MEM_WORDS);

    mem_word_u        mem [`MEM_WORDS];
    logic [IDX_W-1:0] core_idx;
    logic [IDX_W-1:0] tm_idx;
    mem_word_u        merged;
    logic             misaligned;

    // word index, byte offset dropped.
    assign core_idx = core_req.addr[IDX_W+1:2];
    assign tm_idx   = tm_addr[IDX_W+1:2];

    assign core_rd = mem[core_idx].w;
    assign tm_rd   = mem[tm_idx].w;

    always_comb begin
        case (core_req.dt)
            dt_byte: misaligned = 1'b0;
            dt_half: misaligned = core_req.addr[0];
            default: misaligned = |core_req.addr[1:0];
        endcase
    end

    assign core_err = misaligned ? err_misaligned : err_none;

    // narrow writes land in their lanes, the rest of the word is kept.
    always_comb begin
        merged = mem[core_idx];
        case (core_req.dt)
            dt_byte: begin
                merged.b[core_req.addr[1:0]] = core_req.wd.b[0];
            end
            dt_half: begin
                merged.b[{core_req.addr[1], 1'b0}] = core_req.wd.b[0];
                merged.b[{core_req.addr[1], 1'b1}] = core_req.wd.b[1];
            end
            default: begin
                merged = core_req.wd;
            end
        endcase
    end

    // core port is read-only once test mode is on.
    always_ff @(posedge clk_1khz, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (core_req.we && !misaligned && !tm) begin
            mem[core_idx] <= merged;
        end
    end
endmodule

/* finish_monitor.sv */
`include "dump_macros.svh"

module finish_monitor #(
    parameter int DRAIN_CYCLES = `DRAIN_CYCLES
) (
    input  logic        clk_1khz,
    input  logic        rst,
    input  logic [31:0] pc,
    output logic        finished,
    output logic        drained,
    output logic        tm
);
    localparam int CNT_W = $clog2(DRAIN_CYCLES + 1);

    logic [CNT_W-1:0] drain_cnt;
    logic             drain_done;

    // first hit on the last pc, held until reset.
    always_ff @(posedge clk_1khz, posedge rst) begin
        if (rst) begin
            finished <= 1'b0;
        end else if (pc == `LAST_PC) begin
            finished <= 1'b1;
        end
    end

    // saturating drain count.
    always_ff @(posedge clk_1khz, posedge rst) begin
        if (rst) begin
            drain_cnt <= '0;
        end else if (finished && !drain_done) begin
            drain_cnt <= drain_cnt + 1'b1;
        end
    end

    assign drain_done = drain_cnt == CNT_W'(DRAIN_CYCLES);

    assign drained = drain_done;
    assign tm      = drain_done;
endmodule

/* mem_send_ctrl.sv */
`include "dump_macros.svh"

module mem_send_ctrl
    import spi_pkg::*;
#(
    parameter logic [31:0] START_ADDR = `DATA_START_ADDR,
    parameter logic [31:0] END_ADDR   = `DATA_END_ADDR
) (
    input  logic        clk_1khz,
    input  logic        rst,
    input  logic        tm,
    input  logic [31:0] tm_rd,
    input  logic        busy,
    output logic [31:0] tm_addr,
    output send_req_t   send
);
    typedef enum logic [2:0] {
        st_idle,
        st_send_word,
        st_wait_busy,
        st_wait_word,
        st_finished
    } state_e;

    state_e      state;
    logic [31:0] addr;

    always_ff @(posedge clk_1khz, posedge rst) begin
        if (rst) begin
            state <= st_idle;
            addr  <= START_ADDR;
        end else begin
            case (state)
                st_idle: begin
                    if (tm) begin
                        state <= st_send_word;
                    end
                end
                st_send_word: state <= st_wait_busy;
                // en stays up until the master takes the word.
                st_wait_busy: begin
                    if (busy) begin
                        state <= st_wait_word;
                    end
                end
                st_wait_word: begin
                    if (!busy) begin
                        if (addr == END_ADDR) begin
                            state <= st_finished;
                        end else begin
                            state <= st_send_word;
                            addr  <= addr + 32'd4;
                        end
                    end
                end
                default: state <= state;
            endcase
        end
    end

    assign tm_addr = addr;

    // memory read is combinational, so the word follows the address.
    assign send = '{
        en:   (state == st_send_word) || (state == st_wait_busy),
        word: tm_rd
    };
endmodule

/* spi_master_w.sv */
`include "dump_macros.svh"

module spi_master_w
    import spi_pkg::*;
#(
    parameter int SCK_WIDTH_CLKS = `SCK_PULSE_WIDTH
) (
    input  logic      clk_1khz,
    input  logic      rst,
    input  send_req_t send,
    output logic      busy,
    output spi_pins_t spi
);
    localparam int DIV_W = $clog2(SCK_WIDTH_CLKS + 1);

    logic [DIV_W-1:0] div_cnt;
    logic [4:0]       bit_cnt;
    logic             sck;
    logic [31:0]      shreg;
    logic             accept;
    logic             half_done;

    assign accept    = !busy && send.en;
    assign half_done = div_cnt == DIV_W'(SCK_WIDTH_CLKS - 1);

    always_ff @(posedge clk_1khz, posedge rst) begin
        if (rst) begin
            busy    <= 1'b0;
            sck     <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
        end else if (accept) begin
            busy    <= 1'b1;
            sck     <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
        end else if (busy) begin
            if (half_done) begin
                div_cnt <= '0;
                sck     <= ~sck;
                // a falling edge ends one bit.
                if (sck) begin
                    bit_cnt <= bit_cnt + 5'd1;
                    if (bit_cnt == 5'd31) begin
                        busy <= 1'b0;
                    end
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // msb first, next bit moves up on the falling edge.
    always_ff @(posedge clk_1khz) begin
        if (accept) begin
            shreg <= send.word;
        end else if (busy && half_done && sck) begin
            shreg <= {shreg[30:0], 1'b0};
        end
    end

    assign spi = '{
        mosi: busy & shreg[31],
        ss:   ~busy,
        sck:  sck
    };
endmodule

/* mem_dump_top.sv */
module mem_dump_top
    import mem_pkg::*;
    import spi_pkg::*;
(
    input  logic        clk_1khz,
    input  logic        rst,
    input  mem_req_t    core_req,
    input  logic [31:0] pc,
    output logic [31:0] core_rd,
    output errno_e      core_err,
    output logic        finished,
    output logic        drained,
    output spi_pins_t   spi
);
    logic        tm;
    logic [31:0] tm_addr;
    logic [31:0] tm_rd;
    send_req_t   send;
    logic        busy;

    data_mem mem0 (
        .clk_1khz (clk_1khz),
        .rst      (rst),
        .core_req (core_req),
        .tm       (tm),
        .tm_addr  (tm_addr),
        .core_rd  (core_rd),
        .core_err (core_err),
        .tm_rd    (tm_rd)
    );

    finish_monitor fin0 (
        .clk_1khz (clk_1khz),
        .rst      (rst),
        .pc       (pc),
        .finished (finished),
        .drained  (drained),
        .tm       (tm)
    );

    mem_send_ctrl ctrl0 (
        .clk_1khz (clk_1khz),
        .rst      (rst),
        .tm       (tm),
        .tm_rd    (tm_rd),
        .busy     (busy),
        .tm_addr  (tm_addr),
        .send     (send)
    );

    spi_master_w spi0 (
        .clk_1khz (clk_1khz),
        .rst      (rst),
        .send     (send),
        .busy     (busy),
        .spi      (spi)
    );
endmodule

/* mem_dump_sva.sv */
`include "dump_macros.svh"

module mem_dump_sva #(
    parameter bit PIN_SIDE = 1'b0
) (
    input logic        clk_1khz,
    input logic        rst,
    input logic        en,
    input logic        busy,
    input logic        ss,
    input logic        sck,
    input logic [31:0] tm_addr
);
    timeunit 1ns;
    timeprecision 100ps;

    if (PIN_SIDE) begin : g_pins
        // an idle master keeps the frame closed and sck at rest.
        a_ss_idle: assert property (@(posedge clk_1khz) disable iff (rst)
            !busy |-> (ss && !sck))
            else $error("ss low or sck high while the master is idle");
    end else begin : g_ctrl
        // a new word is only offered once the master is idle.
        a_en_idle: assert property (@(posedge clk_1khz) disable iff (rst)
            $rose(en) |-> !busy)
            else $error("send.en rose while busy was high");

        // word aligned and inside the data region.
        a_addr_range: assert property (@(posedge clk_1khz) disable iff (rst)
            ((tm_addr - `DATA_START_ADDR) <= (`DATA_END_ADDR - `DATA_START_ADDR))
            && (tm_addr[1:0] == 2'b00))
            else $error("tm_addr 0x%08h outside the data region", tm_addr);
    end
endmodule

// the controller has no pins and the master has no address.
bind mem_send_ctrl mem_dump_sva #(.PIN_SIDE(1'b0)) sva_ctrl (
    .clk_1khz (clk_1khz),
    .rst      (rst),
    .en       (send.en),
    .busy     (busy),
    .ss       (1'b1),
    .sck      (1'b0),
    .tm_addr  (tm_addr)
);

bind spi_master_w mem_dump_sva #(.PIN_SIDE(1'b1)) sva_spi (
    .clk_1khz (clk_1khz),
    .rst      (rst),
    .en       (send.en),
    .busy     (busy),
    .ss       (spi.ss),
    .sck      (spi.sck),
    .tm_addr  (`DATA_START_ADDR)
);

/* tb_mem_dump.sv */
`include "dump_macros.svh"

module tb_mem_dump
    import mem_pkg::*;
    import spi_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_WORDS = (`DATA_END_ADDR - `DATA_START_ADDR) / 4 + 1;

    logic        clk_1khz;
    logic        rst;
    mem_req_t    core_req;
    logic [31:0] pc;
    logic [31:0] core_rd;
    errno_e      core_err;
    logic        finished;
    logic        drained;
    spi_pins_t   spi;

    logic [31:0] shadow [`MEM_WORDS];
    logic [31:0] lcg_state;
    logic        dump_mode;
    logic [31:0] cap_word;
    logic        prev_sck;
    logic        prev_ss;
    int          cap_bits;
    int          dump_count;
    int          value_errs;
    int          other_errs;

    mem_dump_top dut0 (
        .clk_1khz (clk_1khz),
        .rst      (rst),
        .core_req (core_req),
        .pc       (pc),
        .core_rd  (core_rd),
        .core_err (core_err),
        .finished (finished),
        .drained  (drained),
        .spi      (spi)
    );

    always #4 clk_1khz = ~clk_1khz;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic errno_e expect_err(input logic [31:0] addr, input mem_dt_e dt);
        if (dt == dt_byte) begin
            return err_none;
        end
        if (dt == dt_half) begin
            return addr[0] ? err_misaligned : err_none;
        end
        return (addr[1:0] != 2'b00) ? err_misaligned : err_none;
    endfunction

    // expected word after one request, lanes selected by shifted masks.
    function automatic logic [31:0] expect_word(input logic [31:0] old, input logic [31:0] addr,
                                                input logic [31:0] data, input mem_dt_e dt,
                                                input logic blocked);
        logic [31:0] mask;
        logic [31:0] val;
        if (blocked || expect_err(addr, dt) == err_misaligned) begin
            return old;
        end
        case (dt)
            dt_byte: begin
                mask = 32'h0000_00FF << (8 * addr[1:0]);
                val  = {24'b0, data[7:0]} << (8 * addr[1:0]);
            end
            dt_half: begin
                mask = 32'h0000_FFFF << (16 * addr[1]);
                val  = {16'b0, data[15:0]} << (16 * addr[1]);
            end
            default: begin
                mask = 32'hFFFF_FFFF;
                val  = data;
            end
        endcase
        return (old & ~mask) | (val & mask);
    endfunction

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            value_errs++;
            $display("** Error: %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_err(input string name, input errno_e got, input errno_e exp);
        if (got !== exp) begin
            value_errs++;
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_flags(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            value_errs++;
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic do_write(input logic [31:0] addr, input logic [31:0] data, input mem_dt_e dt);
        logic [3:0]  idx;
        logic [31:0] exp_w;
        errno_e      exp_e;
        @(negedge clk_1khz);
        idx   = addr[5:2];
        exp_e = expect_err(addr, dt);
        exp_w = expect_word(shadow[idx], addr, data, dt, dump_mode);
        core_req.addr = addr;
        core_req.wd.w = data;
        core_req.we   = 1'b1;
        core_req.dt   = dt;
        #1 check_err("core_err", core_err, exp_e);
        @(negedge clk_1khz);
        core_req.we = 1'b0;
        #1 check_word("core_rd", core_rd, exp_w);
        shadow[idx] = exp_w;
    endtask

    task automatic read_all();
        for (int i = 0; i < `MEM_WORDS; i++) begin
            @(negedge clk_1khz);
            core_req.addr = 32'(i * 4);
            core_req.we   = 1'b0;
            core_req.dt   = dt_word;
            #1 check_word("core_rd", core_rd, shadow[i]);
            check_err("core_err", core_err, err_none);
        end
    endtask

    // spi capture, sampled on the falling clock edge where the pins are settled.
    always @(negedge clk_1khz) begin
        if (!rst) begin
            if (spi.sck && !prev_sck) begin
                if (spi.ss) begin
                    other_errs++;
                    $display("sck rose while ss was high");
                end else begin
                    cap_word = {cap_word[30:0], spi.mosi};
                    cap_bits++;
                end
            end
            if (!spi.ss && prev_ss) begin
                cap_bits = 0;
            end
            if (spi.ss && !prev_ss) begin
                if (cap_bits != 32) begin
                    other_errs++;
                    $display("spi frame ended after %0d bits instead of 32", cap_bits);
                end else if (dump_count >= NUM_WORDS) begin
                    other_errs++;
                    $display("spi sent a word after the end of the data region");
                end else begin
                    check_word($sformatf("spi word %0d", dump_count), cap_word,
                               shadow[`DATA_START_ADDR / 4 + dump_count]);
                    dump_count++;
                end
            end
        end
        prev_sck = spi.sck;
        prev_ss  = spi.ss;
    end

    initial begin
        int          n;
        logic [31:0] r;
        logic [31:0] a;
        clk_1khz   = 1'b0;
        rst        = 1'b1;
        core_req   = '0;
        pc         = '0;
        lcg_state  = 32'd17;
        dump_mode  = 1'b0;
        cap_word   = '0;
        prev_sck   = 1'b0;
        prev_ss    = 1'b1;
        cap_bits   = 0;
        dump_count = 0;
        value_errs = 0;
        other_errs = 0;
        for (int i = 0; i < `MEM_WORDS; i++) begin
            shadow[i] = '0;
        end
        repeat (4) @(negedge clk_1khz);
        rst = 1'b0;

        check_flags("finished/drained", {finished, drained}, 2'b00);
        check_flags("ss/sck", {spi.ss, spi.sck}, 2'b10);
        read_all();

        // word writes over the whole memory.
        for (int i = 0; i < 12; i++) begin
            r = lcg_next();
            do_write({26'b0, r[9:6], 2'b00}, lcg_next(), dt_word);
        end
        read_all();

        // narrow writes, then misaligned ones that must not land.
        for (int i = 0; i < 16; i++) begin
            r = lcg_next();
            a = {26'b0, r[11:6]};
            if (r[31]) begin
                a[0] = 1'b0;
            end
            do_write(a, lcg_next(), r[31] ? dt_half : dt_byte);
        end
        do_write(32'h0000_0005, lcg_next(), dt_half);
        do_write(32'h0000_000A, lcg_next(), dt_word);
        do_write(32'h0000_0011, lcg_next(), dt_word);
        do_write(32'h0000_001F, lcg_next(), dt_word);
        read_all();

        for (int i = 0; i < 10; i++) begin
            @(negedge clk_1khz);
            r  = lcg_next();
            pc = (r == `LAST_PC) ? r ^ 32'h4 : r;
            #1 check_flags("finished/drained", {finished, drained}, 2'b00);
        end

        @(negedge clk_1khz);
        pc = `LAST_PC;
        n  = 0;
        while (!finished && n < 50) begin
            @(negedge clk_1khz);
            n++;
        end
        pc = '0;
        if (!finished) begin
            other_errs++;
            $display("timed out waiting for finished");
        end else begin
            check_word("finished latency", 32'(n), 32'd1);
        end
        n = 0;
        while (!drained && n < 100) begin
            @(negedge clk_1khz);
            n++;
        end
        if (!drained) begin
            other_errs++;
            $display("timed out waiting for drained");
        end else begin
            check_word("drained latency", 32'(n), 32'(`DRAIN_CYCLES));
        end
        check_flags("finished/drained", {finished, drained}, 2'b11);

        // test mode owns the memory now.
        dump_mode = 1'b1;
        for (int i = 0; i < 6; i++) begin
            r = lcg_next();
            do_write({27'b0, r[8:6], 2'b00}, lcg_next(), dt_word);
        end

        n = 0;
        while (dump_count < NUM_WORDS && n < 2000) begin
            @(negedge clk_1khz);
            n++;
        end
        if (dump_count < NUM_WORDS) begin
            other_errs++;
            $display("timed out with %0d of %0d words dumped", dump_count, NUM_WORDS);
        end

        for (int i = 0; i < 300; i++) begin
            @(negedge clk_1khz);
            check_flags("ss/sck", {spi.ss, spi.sck}, 2'b10);
        end

        $display("errors: %0d value, %0d protocol or timeout", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end
endmodule

/* src.f */
+incdir+.
mem_pkg.sv
spi_pkg.sv
data_mem.sv
finish_monitor.sv
mem_send_ctrl.sv
spi_master_w.sv
mem_dump_top.sv
mem_dump_sva.sv
tb_mem_dump.sv
